//--- design/pixel_sequencer.sv
// Video word pixel sequencer
`timescale 1ns/1ps

module pixel_sequencer import video_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [MODE_W-1:0] render_mode,
	input  logic              word_valid,
	input  logic [WORD_W-1:0] word_data,
	output logic              word_ready,
	output logic [WORD_W-1:0] data,
	output logic [PSEL_W-1:0] psel,
	output logic              hvpix,
	output logic              c1
);

	logic [PSEL_W-1:0] last_q;
	logic              at_last;
	logic              take;

	// last position of the word being shown
	assign at_last    = hvpix && (psel == last_q);
	assign word_ready = !hvpix || at_last;
	assign take       = word_valid && word_ready;

	// even positions
	assign c1 = ~psel[0];

	// mode is sampled per word, so a change waits for the next one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hvpix  <= 1'b0;
			psel   <= '0;
			last_q <= '0;
		end else if (take) begin
			hvpix  <= 1'b1;
			psel   <= '0;
			last_q <= last_pos(render_mode);
		end else if (at_last) begin
			// starved, fall back to border
			hvpix <= 1'b0;
			psel  <= '0;
		end else if (hvpix) begin
			psel <= psel + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			data <= word_data;
	end

endmodule

//--- design/video_pkg.sv
// Video output shared definitions

package video_pkg;

	// render modes
	localparam logic [1:0] R_ZX = 2'd0;
	localparam logic [1:0] R_HC = 2'd1;
	localparam logic [1:0] R_XC = 2'd2;
	localparam logic [1:0] R_TX = 2'd3;

	// bus and stream widths
	localparam int ADDR_W     = 4;
	localparam int AXI_DATA_W = 32;
	localparam int WORD_W     = 32;
	localparam int PIX_W      = 8;
	localparam int PSEL_W     = 4;
	localparam int MODE_W     = 2;
	localparam int PAL_W      = 4;

	// register map
	localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h0;
	localparam logic [ADDR_W-1:0] REG_PAL    = 4'h4;
	localparam logic [ADDR_W-1:0] REG_BORDER = 4'h8;

	// control register fields
	localparam int CTRL_MODE  = 0;
	localparam int CTRL_HIRES = 2;
	localparam int CTRL_NOGFX = 3;
	localparam int CTRL_NOTSU = 4;
	localparam int CTRL_GFXOV = 5;
	localparam int CTRL_FLASH = 6;
	localparam int CTRL_TSBRD = 7;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// last pixel position in a word, per mode
	localparam logic [PSEL_W-1:0] LAST_ZX = 4'd15;
	localparam logic [PSEL_W-1:0] LAST_TX = 4'd15;
	localparam logic [PSEL_W-1:0] LAST_HC = 4'd3;
	localparam logic [PSEL_W-1:0] LAST_XC = 4'd1;

	function automatic logic [PSEL_W-1:0] last_pos(input logic [MODE_W-1:0] mode);
		case (mode)
			R_ZX:    last_pos = LAST_ZX;
			R_HC:    last_pos = LAST_HC;
			R_XC:    last_pos = LAST_XC;
			default: last_pos = LAST_TX;
		endcase
	endfunction

endpackage

//--- design/video_regs.sv
// Video control registers
`timescale 1ns/1ps

module video_regs import video_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [ADDR_W-1:0]       awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [AXI_DATA_W-1:0]   wdata,
	input  logic [AXI_DATA_W/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [ADDR_W-1:0]       araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [AXI_DATA_W-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output logic [MODE_W-1:0]       render_mode,
	output logic                    hires,
	output logic                    nogfx,
	output logic                    notsu,
	output logic                    gfxovr,
	output logic                    flash,
	output logic                    ts_border,
	output logic [PAL_W-1:0]        palsel,
	output logic [PIX_W-1:0]        border
);

	logic [7:0]       ctrl_q;
	logic [PAL_W-1:0] pal_q;
	logic [PIX_W-1:0] border_q;
	logic             wr_hs;
	logic             rd_hs;

	assign wr_hs = awready && wready && awvalid && wvalid;
	assign rd_hs = arready && arvalid;

	// write channel, one transaction in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// all fields sit in byte 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q   <= '0;
			pal_q    <= '0;
			border_q <= '0;
		end else if (wr_hs && wstrb[0]) begin
			case (awaddr)
				REG_CTRL:   ctrl_q   <= wdata[7:0];
				REG_PAL:    pal_q    <= wdata[PAL_W-1:0];
				REG_BORDER: border_q <= wdata[PIX_W-1:0];
				default: ;
			endcase
		end
	end

	// read channel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			case (araddr)
				REG_CTRL:   rdata <= AXI_DATA_W'(ctrl_q);
				REG_PAL:    rdata <= AXI_DATA_W'(pal_q);
				REG_BORDER: rdata <= AXI_DATA_W'(border_q);
				default:    rdata <= '0;
			endcase
		end
	end

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	assign render_mode = ctrl_q[CTRL_MODE +: MODE_W];
	assign hires       = ctrl_q[CTRL_HIRES];
	assign nogfx       = ctrl_q[CTRL_NOGFX];
	assign notsu       = ctrl_q[CTRL_NOTSU];
	assign gfxovr      = ctrl_q[CTRL_GFXOV];
	assign flash       = ctrl_q[CTRL_FLASH];
	assign ts_border   = ctrl_q[CTRL_TSBRD];
	assign palsel      = pal_q;
	assign border      = border_q;

endmodule

//--- design/video_render.sv
// Pixel decode and layer mixer
`timescale 1ns/1ps

module video_render import video_pkg::*; (
	input  logic              clk,
	input  logic              c1,
	input  logic              hvpix,
	input  logic              ts_border,
	input  logic              nogfx,
	input  logic              notsu,
	input  logic              gfxovr,
	input  logic              flash,
	input  logic              hires,
	input  logic [PSEL_W-1:0] psel,
	input  logic [PAL_W-1:0]  palsel,
	input  logic [MODE_W-1:0] render_mode,
	input  logic [WORD_W-1:0] data,
	input  logic [PIX_W-1:0]  border,
	input  logic [PIX_W-1:0]  ts_data,
	output logic [PIX_W-1:0]  pix_out
);

	logic [7:0]       zx_attr;
	logic             zx_dot;
	logic             zx_on;
	logic [PIX_W-1:0] zx_pix;
	logic [PIX_W-1:0] tx_pix;
	logic [3:0]       hc_dot;
	logic [PIX_W-1:0] xc_dot;
	logic [PIX_W-1:0] gfx_pix;
	logic             gfx_on;
	logic             tsu_vis;
	logic             gfx_vis;
	logic [PIX_W-1:0] video;
	logic [3:0]       nib_q;

	// ZX and text share the bitmap and attribute layout with msb first
	assign zx_dot  = data[{psel[3], ~psel[2:0]}];
	assign zx_attr = psel[3] ? data[31:24] : data[23:16];
	assign zx_on   = zx_dot ^ (flash & zx_attr[7]);
	assign zx_pix  = {palsel, zx_attr[6], zx_on ? zx_attr[2:0] : zx_attr[5:3]};
	assign tx_pix  = {palsel, zx_dot ? zx_attr[3:0] : zx_attr[7:4]};

	// high nibble first within each byte
	assign hc_dot = data[{psel[1], ~psel[0], 2'b00} +: 4];
	assign xc_dot = data[{psel[0], 3'b000} +: 8];

	always_comb begin
		case (render_mode)
			R_ZX: begin
				gfx_pix = zx_pix;
				gfx_on  = zx_on;
			end
			R_HC: begin
				gfx_pix = {palsel, hc_dot};
				gfx_on  = |hc_dot;
			end
			R_XC: begin
				gfx_pix = xc_dot;
				gfx_on  = |xc_dot;
			end
			default: begin
				gfx_pix = tx_pix;
				gfx_on  = zx_dot;
			end
		endcase
	end

	// layer priority
	assign tsu_vis = (|ts_data[3:0]) && !notsu;
	assign gfx_vis = gfx_on && !nogfx;

	always_comb begin
		if (!hvpix)
			video = (ts_border && tsu_vis) ? ts_data : border;
		else if (gfxovr)
			video = gfx_vis ? gfx_pix : (tsu_vis ? ts_data : border);
		else
			video = tsu_vis ? ts_data : (gfx_vis ? gfx_pix : border);
	end

	// even pixel nibble for hi-res pairs
	always_ff @(posedge clk) begin
		if (c1)
			nib_q <= video[3:0];
	end

	assign pix_out = hires ? {nib_q, video[3:0]} : video;

endmodule

//--- design/video_top.sv
// Video pixel output subsystem
`timescale 1ns/1ps

module video_top import video_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [ADDR_W-1:0]       awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [AXI_DATA_W-1:0]   wdata,
	input  logic [AXI_DATA_W/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [ADDR_W-1:0]       araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [AXI_DATA_W-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	input  logic                    word_valid,
	input  logic [WORD_W-1:0]       word_data,
	output logic                    word_ready,
	input  logic [PIX_W-1:0]        ts_data,
	output logic [PIX_W-1:0]        pix_out
);

	// mode and colour controls
	logic [MODE_W-1:0] render_mode;
	logic              hires;
	logic              nogfx;
	logic              notsu;
	logic              gfxovr;
	logic              flash;
	logic              ts_border;
	logic [PAL_W-1:0]  palsel;
	logic [PIX_W-1:0]  border;

	// sequencer to renderer
	logic [WORD_W-1:0] data;
	logic [PSEL_W-1:0] psel;
	logic              hvpix;
	logic              c1;

	video_regs u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.render_mode (render_mode),
		.hires       (hires),
		.nogfx       (nogfx),
		.notsu       (notsu),
		.gfxovr      (gfxovr),
		.flash       (flash),
		.ts_border   (ts_border),
		.palsel      (palsel),
		.border      (border)
	);

	pixel_sequencer u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.render_mode (render_mode),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.word_ready  (word_ready),
		.data        (data),
		.psel        (psel),
		.hvpix       (hvpix),
		.c1          (c1)
	);

	video_render u_render (
		.clk         (clk),
		.c1          (c1),
		.hvpix       (hvpix),
		.ts_border   (ts_border),
		.nogfx       (nogfx),
		.notsu       (notsu),
		.gfxovr      (gfxovr),
		.flash       (flash),
		.hires       (hires),
		.psel        (psel),
		.palsel      (palsel),
		.render_mode (render_mode),
		.data        (data),
		.border      (border),
		.ts_data     (ts_data),
		.pix_out     (pix_out)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the video subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module video_tb -f video_sub.f -o video_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/video_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation PASSED"
exit 0

//--- testbench/video_tb.sv
// Video subsystem testbench
`timescale 1ns/1ps

module video_tb import video_pkg::*; ;

	localparam int N_TESTS     = 6;
	localparam int MAX_TEST_NS = 20000;
	localparam int HS_LIMIT    = 40;

	logic                    clk;
	logic                    rst_n;
	logic [ADDR_W-1:0]       awaddr, araddr;
	logic                    awvalid, wvalid, bready, arvalid, rready;
	logic                    awready, wready, bvalid, arready, rvalid;
	logic [AXI_DATA_W-1:0]   wdata, rdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic [1:0]              bresp, rresp;
	logic                    word_valid, word_ready;
	logic [WORD_W-1:0]       word_data;
	logic [PIX_W-1:0]        ts_data = '0;
	logic [PIX_W-1:0]        pix_out;

	int mismatches;
	int failures;

	// register values as written by the host
	logic [7:0] ctrl_sh;
	logic [3:0] pal_sh;
	logic [7:0] border_sh;

	// expected display state
	logic        check_en;
	logic        m_show;
	logic [1:0]  m_mode;
	logic [31:0] m_word;
	int          m_pos;
	int          m_last;
	logic [7:0]  prev_v;

	logic       ts_random = 1'b0;
	logic [7:0] ts_fixed = '0;

	video_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// new tile layer byte every pixel clock
	always @(posedge clk) begin
		if (ts_random)
			ts_data <= 8'($urandom());
		else
			ts_data <= ts_fixed;
	end

	function automatic int last_index(input logic [1:0] mode);
		if (mode == R_HC)
			return 3;
		if (mode == R_XC)
			return 1;
		return 15;
	endfunction

	function automatic logic [31:0] ctrl_word(input logic [1:0] mode, input logic hires,
			input logic nogfx, input logic notsu, input logic gfxovr, input logic flash,
			input logic tsb);
		return {24'd0, tsb, flash, gfxovr, notsu, nogfx, hires, mode};
	endfunction

	// expected pixel before hi-res packing
	function automatic logic [7:0] expected_video(input logic show, input logic [1:0] mode,
			input logic [31:0] w, input int pos, input logic [7:0] ts, input logic [7:0] ctrl,
			input logic [3:0] pal, input logic [7:0] bord);
		logic [7:0] attr;
		logic [7:0] gfx;
		logic [3:0] nib;
		logic       dot;
		logic       on;
		logic       ts_vis;
		ts_vis = (ts[3:0] != 4'd0) && !ctrl[4];
		if (!show)
			return (ctrl[7] && ts_vis) ? ts : bord;
		// bitmap bytes msb first with one attribute byte per half word
		dot  = w[(pos / 8) * 8 + 7 - (pos % 8)];
		attr = (pos >= 8) ? w[31:24] : w[23:16];
		case (mode)
			R_ZX: begin
				on  = dot ^ (ctrl[6] & attr[7]);
				gfx = {pal, attr[6], on ? attr[2:0] : attr[5:3]};
			end
			R_TX: begin
				on  = dot;
				gfx = {pal, dot ? attr[3:0] : attr[7:4]};
			end
			R_HC: begin
				nib = w[(pos / 2) * 8 + ((pos % 2 == 1) ? 0 : 4) +: 4];
				on  = (nib != 4'd0);
				gfx = {pal, nib};
			end
			default: begin
				gfx = w[pos * 8 +: 8];
				on  = (gfx != 8'd0);
			end
		endcase
		if (ctrl[5])
			return (on && !ctrl[3]) ? gfx : (ts_vis ? ts : bord);
		if (ts_vis)
			return ts;
		return (on && !ctrl[3]) ? gfx : bord;
	endfunction

	always @(negedge clk) begin : pixel_check
		logic [7:0] exp_v;
		logic [7:0] exp_pix;
		if (check_en) begin
			exp_v   = expected_video(m_show, m_mode, m_word, m_pos, ts_data, ctrl_sh, pal_sh,
				border_sh);
			exp_pix = exp_v;
			if (ctrl_sh[2] && m_show && m_pos % 2 == 1)
				exp_pix = {prev_v[3:0], exp_v[3:0]};
			// in hi-res only the completed pair is defined
			if (!ctrl_sh[2] || (m_show && m_pos % 2 == 1)) begin
				assert (pix_out === exp_pix) else begin
					$display("MISMATCH at %0t: pixel pos %0d got %02h, expected %02h",
						$time, m_pos, pix_out, exp_pix);
					mismatches++;
				end
			end
			assert (word_ready === (!m_show || m_pos == m_last)) else begin
				$display("MISMATCH at %0t: word_ready %b at pos %0d", $time, word_ready, m_pos);
				mismatches++;
			end
			prev_v = exp_v;
			if (word_valid && word_ready) begin
				m_show = 1'b1;
				m_pos  = 0;
				m_word = word_data;
				m_mode = ctrl_sh[1:0];
				m_last = last_index(ctrl_sh[1:0]);
			end else if (m_show && m_pos == m_last) begin
				m_show = 1'b0;
			end else if (m_show) begin
				m_pos++;
			end
		end
	end

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] val, input int hold);
		int n;
		n = 0;
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= val;
		wstrb   <= 4'hf;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(negedge clk);
		while (!(awready && wready) && n < HS_LIMIT) begin
			n++;
			@(negedge clk);
		end
		assert (n < HS_LIMIT) else begin
			$display("AXI write to %h was never accepted", addr);
			failures++;
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		// new value is live from this edge on
		case (addr)
			REG_CTRL:   ctrl_sh = val[7:0];
			REG_PAL:    pal_sh = val[3:0];
			REG_BORDER: border_sh = val[7:0];
			default: ;
		endcase
		n = 0;
		@(negedge clk);
		while (!bvalid && n < HS_LIMIT) begin
			n++;
			@(negedge clk);
		end
		assert (bvalid && bresp == RESP_OKAY) else begin
			$display("AXI write to %h got no OKAY response", addr);
			failures++;
		end
		repeat (hold) @(posedge clk);
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] val, input int hold);
		int n;
		n = 0;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(negedge clk);
		while (!arready && n < HS_LIMIT) begin
			n++;
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		while (!rvalid && n < HS_LIMIT) begin
			n++;
			@(negedge clk);
		end
		assert (rvalid && rresp == RESP_OKAY) else begin
			$display("AXI read of %h got no OKAY response", addr);
			failures++;
		end
		val = rdata;
		repeat (hold) @(posedge clk);
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic check_read(input logic [3:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		axi_read(addr, got, 2);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: register %h read %h, expected %h", $time, addr, got, exp);
			mismatches++;
		end
	endtask

	// returns on the edge that transfers the word
	task automatic push_word(input logic [31:0] w);
		int n;
		n = 0;
		@(posedge clk);
		word_valid <= 1'b1;
		word_data  <= w;
		@(negedge clk);
		while (!word_ready && n < HS_LIMIT) begin
			n++;
			@(negedge clk);
		end
		assert (n < HS_LIMIT) else begin
			$display("word stream stalled, word_ready never rose");
			failures++;
		end
		@(posedge clk);
		word_valid <= 1'b0;
	endtask

	task automatic stream_words(input int count, input logic sparse);
		for (int i = 0; i < count; i++)
			push_word(sparse ? ($urandom() & $urandom()) : $urandom());
		// last word runs out after its fixed length
		repeat (last_index(ctrl_sh[1:0]) + 2) @(posedge clk);
	endtask

	task automatic register_access();
		axi_write(REG_CTRL, 32'h0000_00a5, 0);
		axi_write(REG_PAL, 32'hffff_fff9, 3);
		axi_write(REG_BORDER, 32'h0000_003c, 1);
		axi_write(4'hc, 32'hdead_beef, 0);
		check_read(REG_CTRL, 32'h0000_00a5);
		check_read(REG_PAL, 32'h0000_0009);
		check_read(REG_BORDER, 32'h0000_003c);
		check_read(4'hc, 32'h0);
		axi_write(REG_CTRL, 32'h0, 0);
	endtask

	task automatic zx_text_modes();
		ts_random = 1'b1;
		for (int r = 0; r < 6; r++) begin
			axi_write(REG_PAL, 32'($urandom_range(15)), 0);
			axi_write(REG_CTRL, ctrl_word((r % 2 == 0) ? R_ZX : R_TX, 1'b0, 1'b0, 1'b1, 1'b0,
				1'(r / 2), 1'b0), 0);
			stream_words(3, 1'b0);
		end
	endtask

	task automatic colour_modes();
		ts_random = 1'b1;
		for (int r = 0; r < 6; r++) begin
			axi_write(REG_PAL, 32'($urandom_range(15)), 0);
			axi_write(REG_CTRL, ctrl_word((r < 3) ? R_HC : R_XC, 1'b0, 1'b0, 1'($urandom()),
				1'($urandom()), 1'b0, 1'b0), 0);
			stream_words(4, 1'b1);
		end
	endtask

	task automatic layer_mixing();
		ts_random = 1'b1;
		for (int r = 0; r < 8; r++) begin
			axi_write(REG_CTRL, ctrl_word((r % 2 == 1) ? R_XC : R_ZX, 1'b0, 1'($urandom()),
				1'($urandom()), 1'($urandom()), 1'b0, 1'b0), 0);
			stream_words(2, 1'b1);
		end
		// idle display shows the tile over the border only when allowed
		ts_random = 1'b0;
		ts_fixed  = 8'h5a;
		axi_write(REG_BORDER, 32'h0000_0021, 0);
		axi_write(REG_CTRL, ctrl_word(R_ZX, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1), 0);
		repeat (4) @(posedge clk);
		ts_fixed = 8'h50;
		repeat (4) @(posedge clk);
		ts_fixed = 8'h5a;
		axi_write(REG_CTRL, ctrl_word(R_ZX, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0), 0);
		repeat (4) @(posedge clk);
	endtask

	task automatic hires_packing();
		ts_random = 1'b1;
		for (int r = 0; r < 4; r++) begin
			axi_write(REG_PAL, 32'($urandom_range(15)), 0);
			axi_write(REG_CTRL, ctrl_word((r % 2 == 0) ? R_XC : R_HC, 1'b1, 1'b0,
				1'($urandom()), 1'b0, 1'b0, 1'b0), 0);
			stream_words(4, 1'b1);
		end
	endtask

	task automatic stream_starvation();
		logic [31:0] w;
		logic [7:0]  exp;
		ts_random = 1'b0;
		ts_fixed  = 8'h00;
		axi_write(REG_BORDER, 32'h0000_00e7, 0);
		axi_write(REG_CTRL, ctrl_word(R_ZX, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0), 0);
		stream_words(2, 1'b0);
		repeat (5) @(posedge clk);
		w = $urandom();
		push_word(w);
		// position 0 shows in the cycle after the transfer
		@(negedge clk);
		exp = expected_video(1'b1, R_ZX, w, 0, ts_data, ctrl_sh, pal_sh, border_sh);
		assert (pix_out === exp) else begin
			$display("MISMATCH at %0t: first pixel after resume %02h, expected %02h",
				$time, pix_out, exp);
			mismatches++;
		end
		repeat (last_index(R_ZX) + 2) @(posedge clk);
	endtask

	initial begin
		void'($urandom(32'hab0d_b3ed));
		rst_n      = 1'b0;
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		word_valid = 1'b0;
		word_data  = '0;
		mismatches = 0;
		failures   = 0;
		ctrl_sh    = '0;
		pal_sh     = '0;
		border_sh  = '0;
		check_en   = 1'b0;
		m_show     = 1'b0;
		m_mode     = R_ZX;
		m_word     = '0;
		m_pos      = 0;
		m_last     = 0;
		prev_v     = '0;
		repeat (8) @(posedge clk);
		rst_n    <= 1'b1;
		check_en <= 1'b1;
		register_access();
		zx_text_modes();
		colour_modes();
		layer_mixing();
		hires_packing();
		stream_starvation();
		repeat (4) @(posedge clk);
		$display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// upper bound from the number of tests and the longest one
	initial begin
		#(N_TESTS * MAX_TEST_NS);
		$display("watchdog expired at %0t, tests did not complete", $time);
		$display("Errors found");
		$finish;
	end

endmodule

//--- testbench/video_tb_asserts.sv
// Video subsystem protocol checks
`timescale 1ns/1ps

module video_tb_asserts (
	input logic clk,
	input logic rst_n,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic hvpix,
	input logic word_ready
);

	// responses hold until the master takes them
	assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	// idle sequencer always takes a word
	assert property (@(posedge clk) disable iff (!rst_n) !hvpix |-> word_ready)
		else $error("word_ready low while sequencer idle");

	assert property (@(posedge clk) $rose(rst_n) |-> !hvpix)
		else $error("hvpix high right after reset");

endmodule

bind video_top video_tb_asserts u_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.bvalid     (bvalid),
	.bready     (bready),
	.rvalid     (rvalid),
	.rready     (rready),
	.hvpix      (hvpix),
	.word_ready (word_ready)
);

//--- video_sub.f
design/video_pkg.sv
design/video_regs.sv
design/pixel_sequencer.sv
design/video_render.sv
design/video_top.sv
testbench/video_tb_asserts.sv
testbench/video_tb.sv
